/* src.f */
rtl/mem_pkg.sv
rtl/write_steer.sv
rtl/pivot_banks.sv
rtl/cache_table.sv
rtl/read_merge.sv
rtl/mem_2r2w_top.sv
test/tb_mem_2r2w.sv

/* Bender.yml */
package:
  name: mem_2r2w

sources:
  - rtl/mem_pkg.sv
  - rtl/write_steer.sv
  - rtl/pivot_banks.sv
  - rtl/cache_table.sv
  - rtl/read_merge.sv
  - rtl/mem_2r2w_top.sv
  - target: test
    files:
      - test/tb_mem_2r2w.sv

/* test/tb_mem_2r2w.sv */
`timescale 1ns/100ps

module tb_mem_2r2w import mem_pkg::*; ();

  localparam int TEST_CYCLES = 600;  // reset, sweep, directed and random cycles.

  logic    clk;
  logic    rstvld;
  wr_req_t wr_req [NUMWRPT];
  rd_req_t rd_req [NUMRDPT];
  rd_rsp_t rd_rsp [NUMRDPT];
  logic    ready;

  data_t       model [2**BITADDR];
  data_t       exp_q [NUMRDPT];
  logic        acc_q [NUMRDPT];
  logic        chk_on;
  logic [15:0] lfsr;
  int          wait_cnt;
  int          rdy_cnt;
  logic        exp_ready;

  mem_2r2w_top DUT (
    .clk    (clk),
    .rstvld (rstvld),
    .wr_req (wr_req),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .ready  (ready)
  );

  always #10 clk = ~clk;

  // galois lfsr, one step per bit taken.
  function automatic data_t take_bits(input int n);
    data_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v    = {v[WIDTH-2:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
    end
    return v;
  endfunction

  function automatic wr_req_t wr(input logic en, input addr_t a, input data_t d);
    return '{en: en, addr: a, data: d};
  endfunction

  function automatic rd_req_t rd(input logic en, input addr_t a);
    return '{en: en, addr: a};
  endfunction

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic drive(input wr_req_t w0, input wr_req_t w1, input rd_req_t r0,
                       input rd_req_t r1);
    wr_req[0] = w0;
    wr_req[1] = w1;
    rd_req[0] = r0;
    rd_req[1] = r1;
    @(posedge clk);
    #2;
  endtask

  task automatic drive_random();
    wr_req_t w [NUMWRPT];
    rd_req_t r [NUMRDPT];
    for (int p = 0; p < NUMWRPT; p++) begin
      w[p] = wr(1'(take_bits(1)), addr_t'(take_bits(BITADDR)), take_bits(WIDTH));
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      r[p] = rd(1'(take_bits(1)), addr_t'(take_bits(BITADDR)));
    end
    drive(w[0], w[1], r[0], r[1]);
  endtask

  task automatic read_all();
    for (int a = 0; a < 32; a++) begin
      drive('0, '0, rd(1'b1, addr_t'(a)), rd(1'b1, addr_t'(a + 32)));
    end
  endtask

  // ##############################
  // reference model and checks
  // ##############################

  // ready is due once every row has been cleared.
  assign exp_ready = (rdy_cnt == NUMVROW);

  always @(posedge clk) begin
    if (rstvld) begin
      rdy_cnt <= 0;
    end else if (rdy_cnt < NUMVROW) begin
      rdy_cnt <= rdy_cnt + 1;  // one row per cycle.
    end
    for (int p = 0; p < NUMRDPT; p++) begin
      acc_q[p] <= rd_req[p].en && exp_ready;
      if (rd_req[p].en && exp_ready) begin
        exp_q[p] <= model[rd_req[p].addr];  // old word, before this edge's writes.
      end
    end
    for (int p = 0; p < NUMWRPT; p++) begin
      if (wr_req[p].en && exp_ready) begin
        model[wr_req[p].addr] <= wr_req[p].data;  // port 1 lands last.
      end
    end
  end

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_chk
    a_vld: assert property (@(posedge clk) chk_on |-> rd_rsp[p].vld == acc_q[p])
      else report_fail($sformatf("rd_rsp[%0d] valid is %b at %0t but a read was accepted: %b",
                                 p, $sampled(rd_rsp[p].vld), $time, $sampled(acc_q[p])));
    a_data: assert property (@(posedge clk)
                             chk_on && rd_rsp[p].vld |-> rd_rsp[p].data == exp_q[p])
      else report_fail($sformatf("MISMATCH %0t rd_rsp[%0d].data expected %h actual %h", $time,
                                 p, $sampled(exp_q[p]), $sampled(rd_rsp[p].data)));
  end

  a_ready: assert property (@(posedge clk) chk_on |-> ready == exp_ready)
    else report_fail($sformatf("MISMATCH %0t ready expected %b actual %b", $time,
                               $sampled(exp_ready), $sampled(ready)));

  initial begin
    #(2 * TEST_CYCLES * 20);
    report_fail("watchdog expired before the tests completed");
  end

  // ##############################
  // stimulus
  // ##############################

  initial begin
    addr_t a;
    clk     = 1'b0;
    rstvld  = 1'b1;
    chk_on  = 1'b0;
    lfsr    = 16'd3545;
    rdy_cnt = 0;
    for (int p = 0; p < NUMRDPT; p++) begin
      acc_q[p] = 1'b0;
      exp_q[p] = '0;
    end
    for (int i = 0; i < 2**BITADDR; i++) begin
      model[i] = '0;
    end
    wr_req[0] = '0;
    wr_req[1] = '0;
    rd_req[0] = rd(1'b1, 6'd5);  // ignored in reset.
    rd_req[1] = rd(1'b1, 6'd40);
    @(posedge clk);
    #2;
    chk_on = 1'b1;
    repeat (4) @(posedge clk);
    #2;
    rstvld = 1'b0;
    wait_cnt = 0;
    while (ready !== 1'b1) begin
      wait_cnt++;
      assert (wait_cnt <= NUMVROW + 2)
        else report_fail("ready did not rise within NUMVROW+2 cycles of reset release");
      drive_random();
    end
    read_all();
    // same bank pairs, then port 0 on the cached row.
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int r = 0; r < 8; r++) begin
        drive(wr(1'b1, {bank_t'(b), row_t'(r + 8)}, take_bits(WIDTH)),
              wr(1'b1, {bank_t'(b), row_t'(r)}, take_bits(WIDTH)), '0, '0);
        drive(wr(1'b1, {bank_t'(b), row_t'(r)}, take_bits(WIDTH)),
              wr(1'b1, {bank_t'(b ^ 1), row_t'(r + 8)}, take_bits(WIDTH)),
              rd(1'b1, {bank_t'(b), row_t'(r)}), rd(1'b1, {bank_t'(b - 1), row_t'(r)}));
      end
    end
    read_all();
    for (int i = 0; i < 4; i++) begin
      a = addr_t'(take_bits(BITADDR));
      drive(wr(1'b1, a, take_bits(WIDTH)), wr(1'b1, a, take_bits(WIDTH)), '0, '0);
      drive('0, '0, rd(1'b1, a), rd(1'b1, a));
    end
    for (int i = 0; i < 4; i++) begin
      a = addr_t'(take_bits(BITADDR));
      drive(wr(1'b1, a, take_bits(WIDTH)), '0, rd(1'b1, a), '0);
      drive('0, '0, '0, rd(1'b1, a));
    end
    repeat (400) drive_random();
    drive('0, '0, '0, '0);
    drive('0, '0, '0, '0);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* rtl/mem_2r2w_top.sv */
`timescale 1ns/100ps

module mem_2r2w_top import mem_pkg::*; (
  input  logic    clk,
  input  logic    rstvld,
  input  wr_req_t wr_req [NUMWRPT],
  input  rd_req_t rd_req [NUMRDPT],
  output rd_rsp_t rd_rsp [NUMRDPT],
  output logic    ready
);

  map_t      map_look [NUMWRPT];
  row_t      map_row [NUMWRPT];
  data_t     cache_old;
  bank_wr_t  bank_wr [NUMWRPT];
  cache_wr_t cache_wr;
  map_wr_t   map_wr;

  rd_req_t   rd_gated [NUMRDPT];
  addr_t     rd_addr [NUMRDPT];
  row_t      rd_row [NUMRDPT];
  logic      rd_en [NUMRDPT];
  data_t     bank_data [NUMRDPT];
  data_t     cache_data [NUMRDPT];
  map_t      map_data [NUMRDPT];

  write_steer u_steer (
    .clk       (clk),
    .rstvld    (rstvld),
    .wr_req    (wr_req),
    .map_look  (map_look),
    .cache_old (cache_old),
    .ready     (ready),
    .map_row   (map_row),
    .bank_wr   (bank_wr),
    .cache_wr  (cache_wr),
    .map_wr    (map_wr)
  );

  pivot_banks u_banks (
    .clk     (clk),
    .bank_wr (bank_wr),
    .rd_addr (rd_addr),
    .rd_en   (rd_en),
    .rd_data (bank_data)
  );

  cache_table u_cache (
    .clk       (clk),
    .cache_wr  (cache_wr),
    .map_wr    (map_wr),
    .map_row   (map_row),
    .rd_row    (rd_row),
    .rd_en     (rd_en),
    .map_look  (map_look),
    .cache_old (cache_old),
    .rd_cache  (cache_data),
    .rd_map    (map_data)
  );

  for (genvar p = 0; p < NUMRDPT; p++) begin : g_rd
    assign rd_en[p]    = rd_req[p].en && ready;  // reads ignored until init is done.
    assign rd_addr[p]  = rd_req[p].addr;
    assign rd_row[p]   = rd_req[p].addr[BITVROW-1:0];
    assign rd_gated[p] = '{en: rd_en[p], addr: rd_addr[p]};

    read_merge u_merge (
      .clk        (clk),
      .rstvld     (rstvld),
      .rd_req     (rd_gated[p]),
      .bank_data  (bank_data[p]),
      .cache_data (cache_data[p]),
      .map_entry  (map_data[p]),
      .rd_rsp     (rd_rsp[p])
    );
  end

endmodule

/* rtl/read_merge.sv */
`timescale 1ns/100ps

module read_merge import mem_pkg::*; (
  input  logic    clk,
  input  logic    rstvld,
  input  rd_req_t rd_req,
  input  data_t   bank_data,
  input  data_t   cache_data,
  input  map_t    map_entry,
  output rd_rsp_t rd_rsp
);

  logic  vld_q;
  bank_t bank_q;
  logic  cache_hit;

  always_ff @(posedge clk) begin
    if (rstvld) begin
      vld_q <= 1'b0;
    end else begin
      vld_q <= rd_req.en;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_req.en) begin
      bank_q <= rd_req.addr[BITADDR-1 -: BITVBNK];
    end
  end

  // cache holds this word only if the map names our bank.
  assign cache_hit = map_entry.vld && (map_entry.bank == bank_q);

  assign rd_rsp.vld  = vld_q;
  assign rd_rsp.data = cache_hit ? cache_data : bank_data;

endmodule

/* rtl/cache_table.sv */
`timescale 1ns/100ps

module cache_table import mem_pkg::*; (
  input  logic      clk,
  input  cache_wr_t cache_wr,
  input  map_wr_t   map_wr,
  input  row_t      map_row [NUMWRPT],
  input  row_t      rd_row [NUMRDPT],
  input  logic      rd_en [NUMRDPT],
  output map_t      map_look [NUMWRPT],
  output data_t     cache_old,
  output data_t     rd_cache [NUMRDPT],
  output map_t      rd_map [NUMRDPT]
);

  data_t cache_mem [NUMVROW];
  map_t  map_mem [NUMVROW];

  // ##############################
  // cache and map writes
  // ##############################

  always_ff @(posedge clk) begin
    if (cache_wr.en) begin
      cache_mem[cache_wr.row] <= cache_wr.data;
    end
  end

  always_ff @(posedge clk) begin
    if (map_wr.en) begin
      map_mem[map_wr.row] <= map_wr.entry;
    end
  end

  // write side lookup, same cycle.
  always_comb begin
    for (int p = 0; p < NUMWRPT; p++) begin
      map_look[p] = map_mem[map_row[p]];
    end
  end

  // word that may need writing back for port 1's row.
  assign cache_old = cache_mem[map_row[NUMWRPT-1]];

  // ##############################
  // read side
  // ##############################

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUMRDPT; p++) begin
      if (rd_en[p]) begin
        rd_cache[p] <= cache_mem[rd_row[p]];
        rd_map[p]   <= map_mem[rd_row[p]];
      end
    end
  end

endmodule

/* rtl/pivot_banks.sv */
`timescale 1ns/100ps

module pivot_banks import mem_pkg::*; (
  input  logic     clk,
  input  bank_wr_t bank_wr [NUMWRPT],
  input  addr_t    rd_addr [NUMRDPT],
  input  logic     rd_en [NUMRDPT],
  output data_t    rd_data [NUMRDPT]
);

  data_t mem [NUMVBNK][NUMVROW];

  logic  clear_all;
  bank_t rd_bank [NUMRDPT];
  row_t  rd_row [NUMRDPT];

  // never seen outside the init sweep.
  assign clear_all = bank_wr[0].en && bank_wr[1].en &&
                     (bank_wr[0].bank == bank_wr[1].bank);

  // ##############################
  // bank writes
  // ##############################

  always_ff @(posedge clk) begin
    for (int b = 0; b < NUMVBNK; b++) begin
      for (int p = 0; p < NUMWRPT; p++) begin
        if (bank_wr[p].en && (clear_all || (bank_wr[p].bank == bank_t'(b)))) begin
          mem[b][bank_wr[p].row] <= bank_wr[p].data;
        end
      end
    end
  end

  // ##############################
  // registered reads
  // ##############################

  always_comb begin
    for (int p = 0; p < NUMRDPT; p++) begin
      rd_bank[p] = rd_addr[p][BITADDR-1 -: BITVBNK];
      rd_row[p]  = rd_addr[p][BITVROW-1:0];
    end
  end

  always_ff @(posedge clk) begin
    for (int p = 0; p < NUMRDPT; p++) begin
      if (rd_en[p]) begin
        rd_data[p] <= mem[rd_bank[p]][rd_row[p]];  // old word on a same-cycle write.
      end
    end
  end

endmodule

/* rtl/write_steer.sv */
`timescale 1ns/100ps

module write_steer import mem_pkg::*; (
  input  logic      clk,
  input  logic      rstvld,
  input  wr_req_t   wr_req [NUMWRPT],
  input  map_t      map_look [NUMWRPT],
  input  data_t     cache_old,
  output logic      ready,
  output row_t      map_row [NUMWRPT],
  output bank_wr_t  bank_wr [NUMWRPT],
  output cache_wr_t cache_wr,
  output map_wr_t   map_wr
);

  init_e state;
  row_t  sweep_row;

  logic  en [NUMWRPT];
  bank_t bank [NUMWRPT];
  row_t  row [NUMWRPT];

  logic  same_addr;
  logic  en0_keep;
  logic  a_to_cache;
  logic  b_to_cache;
  logic  b_wrback;
  logic  b_inval;

  // ##############################
  // init sweep
  // ##############################

  always_ff @(posedge clk) begin
    if (rstvld) begin
      state     <= INIT_SWEEP;
      sweep_row <= '0;
    end else if (state == INIT_SWEEP) begin
      sweep_row <= sweep_row + 1'b1;
      if (sweep_row == row_t'(NUMVROW-1)) begin
        state <= INIT_DONE;  // last row cleared this cycle.
      end
    end
  end

  assign ready = (state == INIT_DONE);

  // ##############################
  // address split and steering
  // ##############################

  always_comb begin
    for (int p = 0; p < NUMWRPT; p++) begin
      en[p]      = wr_req[p].en && ready;
      bank[p]    = wr_req[p].addr[BITADDR-1 -: BITVBNK];
      row[p]     = wr_req[p].addr[BITVROW-1:0];
      map_row[p] = row[p];
    end
  end

  // port 1 wins on the same address.
  assign same_addr  = en[0] && en[1] && (wr_req[0].addr == wr_req[1].addr);
  assign en0_keep   = en[0] && !same_addr;
  assign a_to_cache = en0_keep && map_look[0].vld && (map_look[0].bank == bank[0]);
  assign b_to_cache = en0_keep && en[1] && (bank[0] == bank[1]) && !a_to_cache;

  // old cached word of another bank goes home.
  assign b_wrback = b_to_cache && map_look[1].vld && (map_look[1].bank != bank[1]);
  assign b_inval  = en[1] && !b_to_cache && map_look[1].vld && (map_look[1].bank == bank[1]);

  always_comb begin
    if (state == INIT_SWEEP) begin
      // same bank on both ports clears the row in every bank.
      for (int p = 0; p < NUMWRPT; p++) begin
        bank_wr[p] = '{en: 1'b1, bank: '0, row: sweep_row, data: '0};
      end
      cache_wr = '{en: 1'b1, row: sweep_row, data: '0};
      map_wr   = '{en: 1'b1, row: sweep_row, entry: '0};
    end else begin
      bank_wr[0].en   = en0_keep && !a_to_cache;
      bank_wr[0].bank = bank[0];
      bank_wr[0].row  = row[0];
      bank_wr[0].data = wr_req[0].data;

      bank_wr[1].en   = b_to_cache ? b_wrback : en[1];
      bank_wr[1].bank = b_to_cache ? map_look[1].bank : bank[1];
      bank_wr[1].row  = row[1];
      bank_wr[1].data = b_to_cache ? cache_old : wr_req[1].data;

      cache_wr.en   = a_to_cache || b_to_cache;
      cache_wr.row  = a_to_cache ? row[0] : row[1];
      cache_wr.data = a_to_cache ? wr_req[0].data : wr_req[1].data;

      map_wr.en          = b_to_cache || b_inval;
      map_wr.row         = row[1];
      map_wr.entry.vld   = b_to_cache;  // invalidate otherwise.
      map_wr.entry.bank  = b_to_cache ? bank[1] : '0;
    end
  end

endmodule

/* rtl/mem_pkg.sv */
package mem_pkg;

  localparam int WIDTH   = 16;
  localparam int NUMVBNK = 4;
  localparam int BITVBNK = 2;
  localparam int NUMVROW = 16;
  localparam int BITVROW = 4;
  localparam int BITADDR = 6;  // bank in the upper bits, row in the lower.
  localparam int NUMRDPT = 2;
  localparam int NUMWRPT = 2;

  typedef logic [WIDTH-1:0]   data_t;
  typedef logic [BITADDR-1:0] addr_t;
  typedef logic [BITVBNK-1:0] bank_t;
  typedef logic [BITVROW-1:0] row_t;

  // which bank's word the cache holds for a row.
  typedef struct packed {
    logic  vld;
    bank_t bank;
  } map_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } wr_req_t;

  typedef struct packed {
    logic  en;
    addr_t addr;
  } rd_req_t;

  typedef struct packed {
    logic  vld;
    data_t data;
  } rd_rsp_t;

  typedef struct packed {
    logic  en;
    bank_t bank;
    row_t  row;
    data_t data;
  } bank_wr_t;

  typedef struct packed {
    logic  en;
    row_t  row;
    data_t data;
  } cache_wr_t;

  typedef struct packed {
    logic en;
    row_t row;
    map_t entry;
  } map_wr_t;

  typedef enum logic {
    INIT_SWEEP,
    INIT_DONE
  } init_e;

endpackage
